//--- main_pkg.sv
`default_nettype none
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// main CPU bus shared definitions
// memory map, sizes, access opcodes and engine states
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package main_pkg;

    // bus and memory widths
    localparam int CPU_AW = 16;
    localparam int ROM_AW = 17;
    localparam int RAM_AW = 11;
    localparam int BANK_W = 3;

    // ROM windows
    localparam int FIXED_WIN_AW = 15;
    localparam int BANK_WIN_AW  = 14;
    localparam logic [BANK_W-1:0] BANK_OFFSET = 3'd2;

    // page decode, compared against the top address bits
    // 0x1800-0x1fff
    localparam logic [4:0] RAM_PAGE  = 5'b00011;
    localparam logic [7:0] CAB_PAGE  = 8'h0a;
    localparam logic [7:0] SYS_PAGE  = 8'h0b;
    localparam logic [7:0] BANK_PAGE = 8'h0c;

    // access queue
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = FIFO_PTR_W + 1;

    // unmapped reads
    localparam logic [7:0] OPEN_BUS = 8'hff;

    typedef enum logic [2:0] {
        OP_ROM_RD,
        OP_RAM_RD,
        OP_RAM_WR,
        OP_CAB_RD,
        OP_SYS_RD,
        OP_OPEN_RD
    } access_op_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ROM_WAIT,
        ST_RAM_WAIT,
        ST_RESP
    } engine_state_t;

endpackage

`default_nettype wire

//--- work_ram.sv
`timescale 1ns/1ns
`default_nettype none
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 2 KB work RAM with one cycle read latency
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module work_ram (
    input  logic                          clk,
    input  logic                          we,
    input  logic [main_pkg::RAM_AW-1:0]   addr,
    input  logic [7:0]                    wdata,
    output logic [7:0]                    rdata
);
    import main_pkg::*;

    logic [7:0] mem [2**RAM_AW];

    // contents are undefined until written by software
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // read port registered every cycle
    always_ff @(posedge clk) begin
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

//--- bus_decoder.sv
`timescale 1ns/1ns
`default_nettype none
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU bus decoder that classifies cycles by the memory map
// holds the ROM bank register and emits queued accesses
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module bus_decoder (
    input  logic                          clk,
    input  logic                          rst,
    // CPU side
    input  logic                          req_valid,
    output logic                          req_ready,
    input  logic [main_pkg::CPU_AW-1:0]   req_addr,
    input  logic                          req_rnw,
    input  logic [7:0]                    req_wdata,
    // queue side
    output logic                          acc_valid,
    input  logic                          acc_ready,
    output main_pkg::access_op_t          acc_op,
    output logic [main_pkg::ROM_AW-1:0]   acc_addr,
    output logic [7:0]                    acc_wdata
);
    import main_pkg::*;

    logic [BANK_W-1:0] bank;
    logic [BANK_W-1:0] bank_win;
    logic [7:0]        page;
    logic              rom_fixed;
    logic              rom_banked;
    logic              ram_hit;
    logic              bank_wr;
    logic              push;

    assign page       = req_addr[CPU_AW-1 -: 8];
    // 0x8000-0xffff
    assign rom_fixed  = req_addr[CPU_AW-1];
    // 0x4000-0x7fff
    assign rom_banked = req_addr[CPU_AW-1 -: 2] == 2'b01;
    assign ram_hit    = req_addr[CPU_AW-1 -: 5] == RAM_PAGE;
    assign bank_wr    = !req_rnw && page == BANK_PAGE;

    // banked window sits two pages above the bank number
    assign bank_win   = bank + BANK_OFFSET;

    always_comb begin
        acc_op   = OP_OPEN_RD;
        acc_addr = '0;
        // every read yields a byte but writes go out only when mapped
        push     = req_rnw;
        if (ram_hit) begin
            acc_op   = req_rnw ? OP_RAM_RD : OP_RAM_WR;
            acc_addr = {{(ROM_AW-RAM_AW){1'b0}}, req_addr[RAM_AW-1:0]};
            push     = 1'b1;
        end else if (req_rnw) begin
            if (rom_fixed) begin
                acc_op   = OP_ROM_RD;
                acc_addr = {{(ROM_AW-FIXED_WIN_AW){1'b0}}, req_addr[FIXED_WIN_AW-1:0]};
            end else if (rom_banked) begin
                acc_op   = OP_ROM_RD;
                acc_addr = {bank_win, req_addr[BANK_WIN_AW-1:0]};
            end else if (page == CAB_PAGE) begin
                acc_op   = OP_CAB_RD;
                // player select only
                acc_addr = {{(ROM_AW-1){1'b0}}, req_addr[0]};
            end else if (page == SYS_PAGE) begin
                acc_op   = OP_SYS_RD;
            end
        end
    end

    // a request is taken whenever the queue has room
    assign req_ready = acc_ready;
    assign acc_valid = req_valid && push;
    assign acc_wdata = req_wdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            bank <= '0;
        end else if (req_valid && req_ready && bank_wr) begin
            bank <= req_wdata[BANK_W-1:0];
        end
    end

    // only RAM writes reach the queue
    assert property (@(posedge clk) disable iff (rst)
        acc_valid && !req_rnw |-> acc_op == OP_RAM_WR);

endmodule

`default_nettype wire

//--- access_fifo.sv
`timescale 1ns/1ns
`default_nettype none
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// access queue between decoder and execution engine
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module access_fifo (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          in_valid,
    output logic                          in_ready,
    input  main_pkg::access_op_t          in_op,
    input  logic [main_pkg::ROM_AW-1:0]   in_addr,
    input  logic [7:0]                    in_wdata,
    output logic                          out_valid,
    input  logic                          out_ready,
    output main_pkg::access_op_t          out_op,
    output logic [main_pkg::ROM_AW-1:0]   out_addr,
    output logic [7:0]                    out_wdata
);
    import main_pkg::*;

    access_op_t          op_mem   [FIFO_DEPTH];
    logic [ROM_AW-1:0]   addr_mem [FIFO_DEPTH];
    logic [7:0]          data_mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] count;
    logic                push;
    logic                pop;

    assign in_ready  = count != FIFO_CNT_W'(FIFO_DEPTH);
    assign out_valid = count != '0;
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    // registered storage with no bypass from input to output
    assign out_op    = op_mem[rd_ptr];
    assign out_addr  = addr_mem[rd_ptr];
    assign out_wdata = data_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            op_mem[wr_ptr]   <= in_op;
            addr_mem[wr_ptr] <= in_addr;
            data_mem[wr_ptr] <= in_wdata;
        end
    end

    // pointers wrap naturally since the depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // occupancy never passes the depth
    assert property (@(posedge clk) disable iff (rst)
        count <= FIFO_CNT_W'(FIFO_DEPTH));
    // pointer distance tracks occupancy
    assert property (@(posedge clk) disable iff (rst)
        wr_ptr - rd_ptr == count[FIFO_PTR_W-1:0]);

endmodule

`default_nettype wire

//--- access_engine.sv
`timescale 1ns/1ns
`default_nettype none
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// access engine, runs queued accesses one at a time
// against ROM, work RAM and cabinet inputs, returns read bytes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module access_engine (
    input  logic                          clk,
    input  logic                          rst,
    // queue side
    input  logic                          acc_valid,
    output logic                          acc_ready,
    input  main_pkg::access_op_t          acc_op,
    input  logic [main_pkg::ROM_AW-1:0]   acc_addr,
    input  logic [7:0]                    acc_wdata,
    // ROM
    output logic                          rom_cs,
    output logic [main_pkg::ROM_AW-1:0]   rom_addr,
    input  logic [7:0]                    rom_data,
    input  logic                          rom_ok,
    // cabinet I/O
    input  logic [1:0]                    start_button,
    input  logic [1:0]                    coin_input,
    input  logic [5:0]                    joystick1,
    input  logic [5:0]                    joystick2,
    input  logic                          service,
    // response
    output logic                          resp_valid,
    input  logic                          resp_ready,
    output logic [7:0]                    resp_data
);
    import main_pkg::*;

    engine_state_t state;
    logic          pop;
    logic          ram_we;
    logic [7:0]    ram_rdata;
    logic [7:0]    cab_byte;
    logic [7:0]    sys_byte;

    // board wiring swaps joystick bit pairs
    function automatic logic [7:0] player_byte(input logic start, input logic [5:0] joy);
        return {start, 1'b1, joy[5:4], joy[2], joy[3], joy[0], joy[1]};
    endfunction

    assign acc_ready  = state == ST_IDLE;
    assign pop        = acc_valid && acc_ready;
    assign resp_valid = state == ST_RESP;

    // RAM is addressed straight from the queue head
    assign ram_we     = pop && acc_op == OP_RAM_WR;

    assign cab_byte = acc_addr[0] ? player_byte(start_button[0], joystick1)
                                  : player_byte(start_button[1], joystick2);
    assign sys_byte = {5'b11111, service, coin_input};

    work_ram work_ram_inst (
        .clk   (clk),
        .we    (ram_we),
        .addr  (acc_addr[RAM_AW-1:0]),
        .wdata (acc_wdata),
        .rdata (ram_rdata)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= ST_IDLE;
            rom_cs <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (pop) begin
                        case (acc_op)
                            OP_ROM_RD: begin
                                state  <= ST_ROM_WAIT;
                                rom_cs <= 1'b1;
                            end
                            OP_RAM_RD: state <= ST_RAM_WAIT;
                            // write completes in the pop cycle
                            OP_RAM_WR: state <= ST_IDLE;
                            default:   state <= ST_RESP;
                        endcase
                    end
                end
                ST_ROM_WAIT: begin
                    if (rom_ok) begin
                        rom_cs <= 1'b0;
                        state  <= ST_RESP;
                    end
                end
                ST_RAM_WAIT: state <= ST_RESP;
                ST_RESP: begin
                    if (resp_ready) state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // response byte only changes outside ST_RESP
    always_ff @(posedge clk) begin
        if (pop && acc_op == OP_ROM_RD) begin
            rom_addr <= acc_addr;
        end
        case (state)
            ST_IDLE: begin
                if (pop) begin
                    case (acc_op)
                        OP_CAB_RD:  resp_data <= cab_byte;
                        OP_SYS_RD:  resp_data <= sys_byte;
                        OP_OPEN_RD: resp_data <= OPEN_BUS;
                        default:    resp_data <= resp_data;
                    endcase
                end
            end
            ST_ROM_WAIT: if (rom_ok) resp_data <= rom_data;
            ST_RAM_WAIT: resp_data <= ram_rdata;
            default:     resp_data <= resp_data;
        endcase
    end

    // ROM request held steady until acknowledged
    assert property (@(posedge clk) disable iff (rst)
        rom_cs && !rom_ok |=> rom_cs && $stable(rom_addr));

endmodule

`default_nettype wire

//--- main_board.sv
`timescale 1ns/1ns
`default_nettype none
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// main CPU bus subsystem, decoder to queue to engine
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module main_board (
    input  logic                          clk,
    input  logic                          rst,
    // CPU requests
    input  logic                          req_valid,
    output logic                          req_ready,
    input  logic [main_pkg::CPU_AW-1:0]   req_addr,
    input  logic                          req_rnw,
    input  logic [7:0]                    req_wdata,
    // read responses
    output logic                          resp_valid,
    input  logic                          resp_ready,
    output logic [7:0]                    resp_data,
    // ROM
    output logic                          rom_cs,
    output logic [main_pkg::ROM_AW-1:0]   rom_addr,
    input  logic [7:0]                    rom_data,
    input  logic                          rom_ok,
    // cabinet I/O
    input  logic [1:0]                    start_button,
    input  logic [1:0]                    coin_input,
    input  logic [5:0]                    joystick1,
    input  logic [5:0]                    joystick2,
    input  logic                          service
);
    import main_pkg::*;

    // decoder to queue
    logic              dec_valid;
    logic              dec_ready;
    access_op_t        dec_op;
    logic [ROM_AW-1:0] dec_addr;
    logic [7:0]        dec_wdata;

    // queue to engine
    logic              que_valid;
    logic              que_ready;
    access_op_t        que_op;
    logic [ROM_AW-1:0] que_addr;
    logic [7:0]        que_wdata;

    bus_decoder bus_decoder_inst (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_addr  (req_addr),
        .req_rnw   (req_rnw),
        .req_wdata (req_wdata),
        .acc_valid (dec_valid),
        .acc_ready (dec_ready),
        .acc_op    (dec_op),
        .acc_addr  (dec_addr),
        .acc_wdata (dec_wdata)
    );

    access_fifo access_fifo_inst (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (dec_valid),
        .in_ready  (dec_ready),
        .in_op     (dec_op),
        .in_addr   (dec_addr),
        .in_wdata  (dec_wdata),
        .out_valid (que_valid),
        .out_ready (que_ready),
        .out_op    (que_op),
        .out_addr  (que_addr),
        .out_wdata (que_wdata)
    );

    access_engine access_engine_inst (
        .clk          (clk),
        .rst          (rst),
        .acc_valid    (que_valid),
        .acc_ready    (que_ready),
        .acc_op       (que_op),
        .acc_addr     (que_addr),
        .acc_wdata    (que_wdata),
        .rom_cs       (rom_cs),
        .rom_addr     (rom_addr),
        .rom_data     (rom_data),
        .rom_ok       (rom_ok),
        .start_button (start_button),
        .coin_input   (coin_input),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .service      (service),
        .resp_valid   (resp_valid),
        .resp_ready   (resp_ready),
        .resp_data    (resp_data)
    );

endmodule

`default_nettype wire

//--- tb_main_board.sv
`timescale 1ns/1ns
`default_nettype none
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the main CPU bus subsystem
// replays file vectors against a ROM model with random stalls
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_main_board;
    import main_pkg::*;

    localparam int MAX_VECS       = 64;
    localparam int NAME_LEN       = 20;
    localparam int CYCLES_PER_VEC = 200;

    logic                clk;
    logic                rst;
    logic                req_valid;
    logic                req_ready;
    logic [CPU_AW-1:0]   req_addr;
    logic                req_rnw;
    logic [7:0]          req_wdata;
    logic                resp_valid;
    logic                resp_ready = 1'b0;
    logic [7:0]          resp_data;
    logic                rom_cs;
    logic [ROM_AW-1:0]   rom_addr;
    logic [7:0]          rom_data = 8'h00;
    logic                rom_ok = 1'b0;
    logic [1:0]          start_button;
    logic [1:0]          coin_input;
    logic [5:0]          joystick1;
    logic [5:0]          joystick2;
    logic                service;

    // vectors as loaded from the file
    logic [8*NAME_LEN-1:0] vec_name    [MAX_VECS];
    logic                  vec_rnw     [MAX_VECS];
    logic [CPU_AW-1:0]     vec_addr    [MAX_VECS];
    logic [7:0]            vec_wdata   [MAX_VECS];
    logic [1:0]            vec_start   [MAX_VECS];
    logic [1:0]            vec_coin    [MAX_VECS];
    logic [5:0]            vec_joy1    [MAX_VECS];
    logic [5:0]            vec_joy2    [MAX_VECS];
    logic                  vec_service [MAX_VECS];
    logic [7:0]            vec_expect  [MAX_VECS];
    int                    num_vecs = 0;
    int                    fd;

    // expected responses in request order
    logic [7:0]            exp_byte_mem [MAX_VECS];
    logic [8*NAME_LEN-1:0] exp_name_mem [MAX_VECS];
    int                    exp_wr = 0;
    int                    exp_rd = 0;
    int                    read_count = 0;
    int                    resp_count = 0;

    int          seq_errors = 0;
    int          check_errors = 0;
    int          timeouts = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    logic        stalled = 1'b0;
    logic [7:0]  held_data = 8'h00;
    logic [31:0] lcg_state = 32'd18;
    logic        rom_busy = 1'b0;
    logic [1:0]  rom_wait = 2'd0;

    main_board main_board_inst (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req_addr     (req_addr),
        .req_rnw      (req_rnw),
        .req_wdata    (req_wdata),
        .resp_valid   (resp_valid),
        .resp_ready   (resp_ready),
        .resp_data    (resp_data),
        .rom_cs       (rom_cs),
        .rom_addr     (rom_addr),
        .rom_data     (rom_data),
        .rom_ok       (rom_ok),
        .start_button (start_button),
        .coin_input   (coin_input),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .service      (service)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // ROM contents are low byte ^ middle byte ^ top bit
    function automatic logic [7:0] rom_byte(input logic [ROM_AW-1:0] a);
        return a[7:0] ^ a[15:8] ^ {7'b0, a[16]};
    endfunction

    // tokens are right aligned so leading null bytes are skipped
    function automatic logic [7:0] first_char(input logic [8*NAME_LEN-1:0] tok);
        logic [7:0] c;
        c = 8'h00;
        for (int i = NAME_LEN - 1; i >= 0; i--) begin
            if (c == 8'h00) c = tok[8*i +: 8];
        end
        return c;
    endfunction

    task finish_run();
        int total;
        total = seq_errors + check_errors;
        $display("errors: %0d, timeouts: %0d", total, timeouts);
        if (total == 0 && timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    task load_vectors();
        logic [8*NAME_LEN-1:0] tok;
        logic [8*128-1:0]      skip_line;
        logic [7:0]            rw_tok;
        logic [CPU_AW-1:0]     f_addr;
        logic [7:0]            f_wdata;
        logic [1:0]            f_start;
        logic [1:0]            f_coin;
        logic [5:0]            f_joy1;
        logic [5:0]            f_joy2;
        logic                  f_service;
        logic [7:0]            f_expect;
        int                    code;
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tok);
            if (code == 1 && first_char(tok) == "#") begin
                code = $fgets(skip_line, fd);
            end else if (code == 1) begin
                code = $fscanf(fd, "%s %h %h %h %h %h %h %h %h", rw_tok, f_addr, f_wdata,
                               f_start, f_coin, f_joy1, f_joy2, f_service, f_expect);
                if (code != 9 || num_vecs >= MAX_VECS) begin
                    $display("bad or excess line in main_tests.txt after %0d vectors",
                             num_vecs);
                    seq_errors++;
                end else begin
                    vec_name[num_vecs]    = tok;
                    vec_rnw[num_vecs]     = rw_tok == "R";
                    vec_addr[num_vecs]    = f_addr;
                    vec_wdata[num_vecs]   = f_wdata;
                    vec_start[num_vecs]   = f_start;
                    vec_coin[num_vecs]    = f_coin;
                    vec_joy1[num_vecs]    = f_joy1;
                    vec_joy2[num_vecs]    = f_joy2;
                    vec_service[num_vecs] = f_service;
                    vec_expect[num_vecs]  = f_expect;
                    if (vec_rnw[num_vecs]) read_count++;
                    num_vecs++;
                end
            end
        end
        if (num_vecs == 0) begin
            $display("no test vectors found in main_tests.txt");
            seq_errors++;
        end
    endtask

    task automatic apply_vector(input int idx);
        if (start_button != vec_start[idx] || coin_input != vec_coin[idx] ||
            joystick1 != vec_joy1[idx] || joystick2 != vec_joy2[idx] ||
            service != vec_service[idx]) begin
            // inputs are sampled at pop so pending reads finish first
            req_valid <= 1'b0;
            while (exp_wr != exp_rd) @(posedge clk);
            start_button <= vec_start[idx];
            coin_input   <= vec_coin[idx];
            joystick1    <= vec_joy1[idx];
            joystick2    <= vec_joy2[idx];
            service      <= vec_service[idx];
        end
        req_valid <= 1'b1;
        req_addr  <= vec_addr[idx];
        req_rnw   <= vec_rnw[idx];
        req_wdata <= vec_wdata[idx];
        @(posedge clk);
        while (!req_ready) @(posedge clk);
        if (vec_rnw[idx]) begin
            exp_byte_mem[exp_wr] = vec_expect[idx];
            exp_name_mem[exp_wr] = vec_name[idx];
            exp_wr++;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ROM model and response back-pressure
    always @(posedge clk) begin
        if (rst) begin
            rom_ok     <= 1'b0;
            resp_ready <= 1'b0;
            rom_busy = 1'b0;
        end else begin
            lcg_state = lcg_next(lcg_state);
            resp_ready <= lcg_state[17:16] != 2'b00;
            if (rom_ok) begin
                rom_ok <= 1'b0;
                rom_busy = 1'b0;
            end else if (rom_cs && !rom_busy) begin
                rom_busy = 1'b1;
                rom_wait = lcg_state[20:19];
            end
            if (rom_busy) begin
                if (rom_wait == 2'd0) begin
                    rom_ok   <= 1'b1;
                    rom_data <= rom_byte(rom_addr);
                end else begin
                    rom_wait = rom_wait - 2'd1;
                end
            end
        end
    end

    // response checker
    always @(posedge clk) begin
        if (!rst) begin
            if (stalled && (resp_valid !== 1'b1 || resp_data !== held_data)) begin
                $display("response was withdrawn or changed while resp_ready was low");
                check_errors++;
            end
            if (resp_valid && resp_ready) begin
                resp_count++;
                if (exp_rd == exp_wr) begin
                    $display("response 0x%02h arrived with no read outstanding", resp_data);
                    check_errors++;
                end else begin
                    if (resp_data !== exp_byte_mem[exp_rd]) begin
                        $display("ERROR %0s: expected 0x%02h, actual 0x%02h",
                                 exp_name_mem[exp_rd], exp_byte_mem[exp_rd], resp_data);
                        check_errors++;
                    end
                    exp_rd++;
                end
            end
        end
        stalled   = !rst && resp_valid && !resp_ready;
        held_data = resp_data;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("timeout, run did not finish within %0d cycles", cycle_limit);
            timeouts++;
            finish_run();
        end
    end

    initial begin
        rst          = 1'b1;
        req_valid    = 1'b0;
        req_addr     = '0;
        req_rnw      = 1'b1;
        req_wdata    = 8'h00;
        start_button = 2'b00;
        coin_input   = 2'b00;
        joystick1    = 6'h00;
        joystick2    = 6'h00;
        service      = 1'b0;
        fd = $fopen("main_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open main_tests.txt for reading");
            seq_errors++;
            finish_run();
        end else begin
            load_vectors();
            $fclose(fd);
            cycle_limit = CYCLES_PER_VEC * num_vecs;
            repeat (16) @(posedge clk);
            if (req_ready !== 1'b1) begin
                $display("ERROR reset_req_ready: expected 1, actual %b", req_ready);
                seq_errors++;
            end
            if (resp_valid !== 1'b0 || rom_cs !== 1'b0) begin
                $display("ERROR reset_outputs: expected 00, actual %b%b", resp_valid, rom_cs);
                seq_errors++;
            end
            rst <= 1'b0;
            for (int i = 0; i < num_vecs; i++) begin
                apply_vector(i);
            end
            req_valid <= 1'b0;
            while (exp_rd != exp_wr) @(posedge clk);
            // window for stray responses
            repeat (20) @(posedge clk);
            if (resp_count != read_count) begin
                $display("ERROR response_count: expected %0d, actual %0d",
                         read_count, resp_count);
                seq_errors++;
            end
            finish_run();
        end
    end

endmodule

`default_nettype wire

//--- main_tests.txt
# name rw addr wdata start coin joy1 joy2 service expect, all numbers in hex
# expect is ignored on W lines
rom_fix_lo     R 8000 00 0 0 00 00 0 00
rom_fix_mid    R 8123 00 0 0 00 00 0 22
rom_fix_top    R ffff 00 0 0 00 00 0 80
rom_fix_odd    R c5a0 00 0 0 00 00 0 e5
bank_set0      W 0c00 00 0 0 00 00 0 00
bank0_lo       R 4000 00 0 0 00 00 0 80
bank0_hi       R 7fff 00 0 0 00 00 0 40
bank_set3      W 0cff fb 0 0 00 00 0 00
bank3_lo       R 4000 00 0 0 00 00 0 41
bank3_mid      R 5234 00 0 0 00 00 0 67
bank_set7      W 0c80 07 0 0 00 00 0 00
bank7_mid      R 6abc 00 0 0 00 00 0 d6
bank7_lo       R 4001 00 0 0 00 00 0 41
ram_wr_lo      W 1800 5a 0 0 00 00 0 00
ram_wr_hi      W 1fff a5 0 0 00 00 0 00
ram_wr_mid     W 1abc 3c 0 0 00 00 0 00
ram_rd_lo      R 1800 00 0 0 00 00 0 5a
ram_rd_hi      R 1fff 00 0 0 00 00 0 a5
ram_rd_mid     R 1abc 00 0 0 00 00 0 3c
ram_wr_again   W 1800 c3 0 0 00 00 0 00
ram_rd_again   R 1800 00 0 0 00 00 0 c3
open_zero      R 0000 00 0 0 00 00 0 ff
open_below_ram R 17ff 00 0 0 00 00 0 ff
open_above_ram R 2000 00 0 0 00 00 0 ff
open_past_bank R 0d00 00 0 0 00 00 0 ff
open_below_rom R 3fff 00 0 0 00 00 0 ff
drop_rom_fix   W 8000 11 0 0 00 00 0 00
drop_rom_bank  W 4000 22 0 0 00 00 0 00
rom_after_wr   R 8000 00 0 0 00 00 0 00
bank_after_wr  R 4001 00 0 0 00 00 0 41
drop_low       W 0800 77 0 0 00 00 0 00
drop_high      W 2000 66 0 0 00 00 0 00
drop_cab       W 0a00 55 0 0 00 00 0 00
drop_sys       W 0b00 44 0 0 00 00 0 00
ram_kept       R 1800 00 0 0 00 00 0 c3
mix_rom        R 8001 00 0 0 00 00 0 01
mix_ram        R 1fff 00 0 0 00 00 0 a5
mix_sys_idle   R 0b00 00 0 0 00 00 0 f8
mix_rom_hi     R ff00 00 0 0 00 00 0 7f
mix_open       R 0000 00 0 0 00 00 0 ff
cab_a_p1       R 0a01 00 1 2 29 16 1 e6
cab_a_p2       R 0a00 00 1 2 29 16 1 59
cab_a_p1_end   R 0aff 00 1 2 29 16 1 e6
cab_a_sys      R 0b00 00 1 2 29 16 1 fe
cab_b_p1       R 0a01 00 2 1 12 2d 0 51
cab_b_p2       R 0a00 00 2 1 12 2d 0 ee
cab_b_sys      R 0bff 00 2 1 12 2d 0 f9

//--- src.f
main_pkg.sv
work_ram.sv
bus_decoder.sv
access_fifo.sv
access_engine.sv
main_board.sv
tb_main_board.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --timing --assert
TOP       = tb_main_board
FILELIST  = src.f
OBJ_DIR   = obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)
